//--- controlUnit.f
verilog/controlPkg.sv
verilog/fetchDecodeSequencer.sv
verilog/executeSequencer.sv
verilog/controlWordRegister.sv
verilog/controlUnit.sv
sim/controlUnitProps.sv
sim/controlUnitTb.sv

//--- sim/controlUnitProps.sv
`timescale 1ns/1ns

module controlUnitProps (
    input logic       clock,
    input logic       reset,
    input logic       pcWrite,
    input logic       irWrite,
    input logic       regWrite,
    input logic       aWrite,
    input logic       bWrite,
    input logic       aluOutWrite,
    input logic [2:0] aluOp,
    input logic       srcASelect,
    input logic [1:0] srcBSelect,
    input logic [1:0] regDestSelect,
    input logic [3:0] memToRegSelect,
    input logic       shiftAmountSelect,
    input logic       shiftSourceSelect,
    input logic [2:0] shiftCtrl
);

    logic allZero;

    assign allZero = !(pcWrite || irWrite || regWrite || aWrite || bWrite || aluOutWrite ||
        srcASelect || shiftAmountSelect || shiftSourceSelect) &&
        (aluOp == 3'd0) && (srcBSelect == 2'd0) && (regDestSelect == 2'd0) &&
        (memToRegSelect == 4'd0) && (shiftCtrl == 3'd0);

    // the instruction register only loads together with the pc
    irWithPc: assert property (@(posedge clock) disable iff (reset) irWrite |-> pcWrite)
        else $error("irWrite raised without pcWrite");

    noWriteDuringFetch: assert property (@(posedge clock) disable iff (reset)
        !(regWrite && irWrite))
        else $error("regWrite and irWrite raised in the same cycle");

    zeroAfterReset: assert property (@(posedge clock) reset |=> allZero)
        else $error("outputs not all zero in the cycle after reset");

endmodule

bind controlUnit controlUnitProps i_controlUnitProps (
    .clock             (clock),
    .reset             (reset),
    .pcWrite           (pcWrite),
    .irWrite           (irWrite),
    .regWrite          (regWrite),
    .aWrite            (aWrite),
    .bWrite            (bWrite),
    .aluOutWrite       (aluOutWrite),
    .aluOp             (aluOp),
    .srcASelect        (srcASelect),
    .srcBSelect        (srcBSelect),
    .regDestSelect     (regDestSelect),
    .memToRegSelect    (memToRegSelect),
    .shiftAmountSelect (shiftAmountSelect),
    .shiftSourceSelect (shiftSourceSelect),
    .shiftCtrl         (shiftCtrl)
);

//--- sim/controlUnitTb.sv
`timescale 1ns/1ns

module controlUnitTb;

    localparam int instructionCount = 400;
    localparam int resetCycles = 3;
    localparam int memoryWaitSteps = 3;
    localparam int longestInstruction = 9;
    localparam int cycleLimit = instructionCount * longestInstruction + resetCycles + 40;

    typedef enum {
        kindAdd, kindSub, kindAnd, kindSlt, kindSll, kindSrl, kindSra,
        kindSllv, kindSrav, kindAddi, kindIllegal
    } instrKindT;

    logic       clock;
    logic       reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       pcWrite;
    logic       irWrite;
    logic       regWrite;
    logic       aWrite;
    logic       bWrite;
    logic       aluOutWrite;
    logic [2:0] aluOp;
    logic       srcASelect;
    logic [1:0] srcBSelect;
    logic [1:0] regDestSelect;
    logic [3:0] memToRegSelect;
    logic       shiftAmountSelect;
    logic       shiftSourceSelect;
    logic [2:0] shiftCtrl;

    controlPkg::controlWordT expectedQueue[$];
    int cycleCount = 0;

    controlUnit i_dut (
        .clock             (clock),
        .reset             (reset),
        .opcode            (opcode),
        .funct             (funct),
        .pcWrite           (pcWrite),
        .irWrite           (irWrite),
        .regWrite          (regWrite),
        .aWrite            (aWrite),
        .bWrite            (bWrite),
        .aluOutWrite       (aluOutWrite),
        .aluOp             (aluOp),
        .srcASelect        (srcASelect),
        .srcBSelect        (srcBSelect),
        .regDestSelect     (regDestSelect),
        .memToRegSelect    (memToRegSelect),
        .shiftAmountSelect (shiftAmountSelect),
        .shiftSourceSelect (shiftSourceSelect),
        .shiftCtrl         (shiftCtrl)
    );

    always #2 clock = ~clock;

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    always @(posedge clock) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycleLimit);
            abortRun();
        end
    end

    function automatic bit isKnownFunct(input logic [5:0] code);
        return code inside {controlPkg::functAdd, controlPkg::functSub, controlPkg::functAnd,
            controlPkg::functSll, controlPkg::functSlt, controlPkg::functSra,
            controlPkg::functSrl, controlPkg::functSllv, controlPkg::functSrav};
    endfunction

    task automatic driveInstruction(input instrKindT kind);
        opcode = controlPkg::opcodeRType;
        funct = 6'($urandom);
        case (kind)
            kindAdd: funct = controlPkg::functAdd;
            kindSub: funct = controlPkg::functSub;
            kindAnd: funct = controlPkg::functAnd;
            kindSlt: funct = controlPkg::functSlt;
            kindSll: funct = controlPkg::functSll;
            kindSrl: funct = controlPkg::functSrl;
            kindSra: funct = controlPkg::functSra;
            kindSllv: funct = controlPkg::functSllv;
            kindSrav: funct = controlPkg::functSrav;
            // addi keeps the random funct so the decoder has to ignore it
            kindAddi: opcode = controlPkg::opcodeAddi;
            default: begin
                if ($urandom % 2) begin
                    do opcode = 6'($urandom);
                    while (opcode == controlPkg::opcodeRType || opcode == controlPkg::opcodeAddi);
                end else begin
                    do funct = 6'($urandom);
                    while (isKnownFunct(funct));
                end
            end
        endcase
    endtask

    function automatic controlPkg::controlWordT fetchStepWord(input int step);
        controlPkg::controlWordT word;
        word = '0;
        if (step <= memoryWaitSteps) begin
            word.aluOp = controlPkg::aluAdd;
            word.srcBSelect = controlPkg::srcBFour;
        end
        if (step == memoryWaitSteps) begin
            word.pcWrite = 1'b1;
            word.irWrite = 1'b1;
        end
        if (step == memoryWaitSteps + 1) begin
            word.aWrite = 1'b1;
            word.bWrite = 1'b1;
        end
        return word;
    endfunction

    function automatic controlPkg::shiftCtrlT shiftDirectionOf(input instrKindT kind);
        if (kind == kindSrl) begin
            return controlPkg::shiftRightLogic;
        end else if (kind == kindSra || kind == kindSrav) begin
            return controlPkg::shiftRightArith;
        end
        return controlPkg::shiftLeft;
    endfunction

    // expected output words of one instruction from fetch step 0 to its last execute step
    task automatic buildExpected(input instrKindT kind);
        controlPkg::controlWordT word;
        expectedQueue.delete();
        for (int step = 0; step < memoryWaitSteps + 3; step++) begin
            expectedQueue.push_back(fetchStepWord(step));
        end
        word = '0;
        case (kind)
            kindAdd, kindSub, kindAnd: begin
                if (kind == kindAdd) begin
                    word.aluOp = controlPkg::aluAdd;
                end else if (kind == kindSub) begin
                    word.aluOp = controlPkg::aluSub;
                end else begin
                    word.aluOp = controlPkg::aluAnd;
                end
                word.aluOutWrite = 1'b1;
                word.srcASelect = 1'b1;
                expectedQueue.push_back(word);
                word.regWrite = 1'b1;
                word.regDestSelect = controlPkg::regDestRd;
                expectedQueue.push_back(word);
            end
            kindAddi: begin
                word.aluOp = controlPkg::aluSub;
                word.aluOutWrite = 1'b1;
                word.srcASelect = 1'b1;
                word.srcBSelect = controlPkg::srcBImmediate;
                expectedQueue.push_back(word);
                word = '0;
                word.aluOp = controlPkg::aluAdd;
                word.srcASelect = 1'b1;
                word.regWrite = 1'b1;
                expectedQueue.push_back(word);
            end
            kindSlt: begin
                word.aluOp = controlPkg::aluSlt;
                word.srcASelect = 1'b1;
                word.regWrite = 1'b1;
                word.regDestSelect = controlPkg::regDestRd;
                word.memToRegSelect = controlPkg::memToRegLessThan;
                expectedQueue.push_back(word);
            end
            kindIllegal: begin
            end
            default: begin
                word.regDestSelect = controlPkg::regDestRd;
                word.memToRegSelect = controlPkg::memToRegShifter;
                word.shiftCtrl = controlPkg::shiftLoad;
                if (kind == kindSll || kind == kindSrl || kind == kindSra) begin
                    word.shiftAmountSelect = 1'b1;
                    word.shiftSourceSelect = 1'b1;
                end
                expectedQueue.push_back(word);
                word.shiftAmountSelect = 1'b0;
                word.shiftSourceSelect = 1'b0;
                word.shiftCtrl = shiftDirectionOf(kind);
                expectedQueue.push_back(word);
                word.shiftCtrl = controlPkg::shiftLeft;
                word.regWrite = 1'b1;
                expectedQueue.push_back(word);
            end
        endcase
    endtask

    task automatic compareOutputs(input controlPkg::controlWordT expected, input string label,
            input int step);
        controlPkg::controlWordT actual;
        actual = '0;
        actual.pcWrite = pcWrite;
        actual.irWrite = irWrite;
        actual.regWrite = regWrite;
        actual.aWrite = aWrite;
        actual.bWrite = bWrite;
        actual.aluOutWrite = aluOutWrite;
        actual.aluOp = controlPkg::aluOpT'(aluOp);
        actual.srcASelect = srcASelect;
        actual.srcBSelect = controlPkg::srcBSelectT'(srcBSelect);
        actual.regDestSelect = controlPkg::regDestSelectT'(regDestSelect);
        actual.memToRegSelect = controlPkg::memToRegSelectT'(memToRegSelect);
        actual.shiftAmountSelect = shiftAmountSelect;
        actual.shiftSourceSelect = shiftSourceSelect;
        actual.shiftCtrl = controlPkg::shiftCtrlT'(shiftCtrl);
        assert (actual === expected) else begin
            $display("FAILED at %0t ns: %s step %0d, expected word %h, got %h",
                $time, label, step, expected, actual);
            abortRun();
        end
    endtask

    initial begin
        instrKindT kind;
        controlPkg::controlWordT expected;
        int unsigned pick;
        int step;
        clock = 1'b0;
        reset = 1'b1;
        opcode = '0;
        funct = '0;
        void'($urandom(58860));
        repeat (resetCycles) begin
            @(negedge clock);
            compareOutputs(controlPkg::idleWord, "reset", 0);
        end
        reset = 1'b0;
        for (int index = 0; index < instructionCount; index++) begin
            // illegal codes come up about once in eleven instructions
            pick = $urandom % 22;
            if (pick < 20) begin
                kind = instrKindT'(pick / 2);
            end else begin
                kind = kindIllegal;
            end
            driveInstruction(kind);
            buildExpected(kind);
            step = 0;
            while (expectedQueue.size() > 0) begin
                expected = expectedQueue.pop_front();
                @(negedge clock);
                compareOutputs(expected, kind.name(), step);
                step++;
            end
        end
        $display("TEST OK");
        $finish;
    end

endmodule

//--- verilog/controlPkg.sv
package controlPkg;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    localparam opcodeT opcodeRType = 6'b000000;
    localparam opcodeT opcodeAddi = 6'b001000;

    localparam functT functAdd = 6'b100000;
    localparam functT functSub = 6'b100010;
    localparam functT functAnd = 6'b100100;
    localparam functT functSll = 6'b000000;
    localparam functT functSlt = 6'b101010;
    localparam functT functSra = 6'b000011;
    localparam functT functSrl = 6'b000010;
    localparam functT functSllv = 6'b000100;
    localparam functT functSrav = 6'b000111;

    typedef enum logic [2:0] {
        aluNone = 3'd0,
        aluAdd = 3'd1,
        aluSub = 3'd2,
        aluAnd = 3'd3,
        aluSlt = 3'd7
    } aluOpT;

    typedef enum logic [2:0] {
        shiftNone = 3'd0,
        shiftLoad = 3'd1,
        shiftLeft = 3'd2,
        shiftRightLogic = 3'd3,
        shiftRightArith = 3'd4
    } shiftCtrlT;

    typedef enum logic [1:0] {
        srcBRegB = 2'd0,
        srcBFour = 2'd1,
        srcBImmediate = 2'd2
    } srcBSelectT;

    typedef enum logic [1:0] {
        regDestRt = 2'd0,
        regDestRd = 2'd1
    } regDestSelectT;

    // one-hot style codes taken from the register file write mux
    typedef enum logic [3:0] {
        memToRegAlu = 4'd0,
        memToRegLessThan = 4'd4,
        memToRegShifter = 4'd8
    } memToRegSelectT;

    typedef enum logic [2:0] {
        classNone = 3'd0,
        classAlu = 3'd1,
        classAddi = 3'd2,
        classSlt = 3'd3,
        classShiftImmediate = 3'd4,
        classShiftVariable = 3'd5
    } instrClassT;

    typedef struct packed {
        logic pcWrite;
        logic irWrite;
        logic regWrite;
        logic aWrite;
        logic bWrite;
        logic aluOutWrite;
        aluOpT aluOp;
        logic srcASelect;
        srcBSelectT srcBSelect;
        regDestSelectT regDestSelect;
        memToRegSelectT memToRegSelect;
        logic shiftAmountSelect;
        logic shiftSourceSelect;
        shiftCtrlT shiftCtrl;
    } controlWordT;

    localparam controlWordT idleWord = '0;

    localparam int fetchWaitCycles = 3;

endpackage

//--- verilog/controlUnit.sv
`timescale 1ns/1ns

module controlUnit (
    input  logic       clock,
    input  logic       reset,
    input  logic [5:0] opcode,
    input  logic [5:0] funct,
    output logic       pcWrite,
    output logic       irWrite,
    output logic       regWrite,
    output logic       aWrite,
    output logic       bWrite,
    output logic       aluOutWrite,
    output logic [2:0] aluOp,
    output logic       srcASelect,
    output logic [1:0] srcBSelect,
    output logic [1:0] regDestSelect,
    output logic [3:0] memToRegSelect,
    output logic       shiftAmountSelect,
    output logic       shiftSourceSelect,
    output logic [2:0] shiftCtrl
);

    logic                    dispatch;
    logic                    done;
    logic                    executeActive;
    controlPkg::instrClassT  instrClass;
    controlPkg::aluOpT       decodedAluOp;
    controlPkg::controlWordT fetchWord;
    controlPkg::controlWordT executeWord;
    controlPkg::controlWordT controlWord;

    fetchDecodeSequencer i_fetchDecodeSequencer (
        .clock      (clock),
        .reset      (reset),
        .opcode     (opcode),
        .funct      (funct),
        .done       (done),
        .dispatch   (dispatch),
        .instrClass (instrClass),
        .aluOp      (decodedAluOp),
        .fetchWord  (fetchWord)
    );

    executeSequencer i_executeSequencer (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .instrClass    (instrClass),
        .aluOp         (decodedAluOp),
        .executeActive (executeActive),
        .done          (done),
        .executeWord   (executeWord)
    );

    controlWordRegister i_controlWordRegister (
        .clock         (clock),
        .reset         (reset),
        .fetchWord     (fetchWord),
        .executeWord   (executeWord),
        .executeActive (executeActive),
        .controlWord   (controlWord)
    );

    assign pcWrite = controlWord.pcWrite;
    assign irWrite = controlWord.irWrite;
    assign regWrite = controlWord.regWrite;
    assign aWrite = controlWord.aWrite;
    assign bWrite = controlWord.bWrite;
    assign aluOutWrite = controlWord.aluOutWrite;
    assign aluOp = controlWord.aluOp;
    assign srcASelect = controlWord.srcASelect;
    assign srcBSelect = controlWord.srcBSelect;
    assign regDestSelect = controlWord.regDestSelect;
    assign memToRegSelect = controlWord.memToRegSelect;
    assign shiftAmountSelect = controlWord.shiftAmountSelect;
    assign shiftSourceSelect = controlWord.shiftSourceSelect;
    assign shiftCtrl = controlWord.shiftCtrl;

endmodule

//--- verilog/controlWordRegister.sv
`timescale 1ns/1ns

module controlWordRegister (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::controlWordT fetchWord,
    input  controlPkg::controlWordT executeWord,
    input  logic                    executeActive,
    output controlPkg::controlWordT controlWord
);

    controlPkg::controlWordT nextWord;

    // the two sequencers never run at once, so the active flag picks the owner
    assign nextWord = executeActive ? executeWord : fetchWord;

    always_ff @(posedge clock) begin
        if (reset) begin
            controlWord <= controlPkg::idleWord;
        end else begin
            controlWord <= nextWord;
        end
    end

endmodule

//--- verilog/executeSequencer.sv
`timescale 1ns/1ns

module executeSequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    dispatch,
    input  controlPkg::instrClassT  instrClass,
    input  controlPkg::aluOpT       aluOp,
    output logic                    executeActive,
    output logic                    done,
    output controlPkg::controlWordT executeWord
);

    logic [1:0]             executeStep;
    logic [1:0]             lastStep;
    controlPkg::instrClassT activeClass;
    controlPkg::aluOpT      activeAluOp;
    controlPkg::shiftCtrlT  shiftDirection;

    always_ff @(posedge clock) begin
        if (reset) begin
            executeActive <= 1'b0;
            executeStep <= '0;
            activeClass <= controlPkg::classNone;
        end else if (dispatch) begin
            executeActive <= 1'b1;
            executeStep <= 2'd1;
            activeClass <= instrClass;
        end else if (done) begin
            executeActive <= 1'b0;
            executeStep <= '0;
        end else if (executeActive) begin
            executeStep <= executeStep + 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (dispatch) begin
            activeAluOp <= aluOp;
        end
    end

    always_comb begin
        case (activeClass)
            controlPkg::classAlu,
            controlPkg::classAddi: lastStep = 2'd2;
            controlPkg::classSlt: lastStep = 2'd1;
            controlPkg::classShiftImmediate,
            controlPkg::classShiftVariable: lastStep = 2'd3;
            default: lastStep = 2'd0;
        endcase
    end

    assign done = executeActive && (executeStep == lastStep);

    always_comb begin
        shiftDirection = controlPkg::shiftNone;
        if (activeClass == controlPkg::classShiftImmediate ||
                activeClass == controlPkg::classShiftVariable) begin
            case (activeAluOp)
                controlPkg::aluSub: shiftDirection = controlPkg::shiftRightLogic;
                controlPkg::aluAnd: shiftDirection = controlPkg::shiftRightArith;
                default: shiftDirection = controlPkg::shiftLeft;
            endcase
        end
    end

    always_comb begin
        executeWord = controlPkg::idleWord;
        case (activeClass)
            controlPkg::classAlu: begin
                executeWord.aluOp = activeAluOp;
                executeWord.aluOutWrite = 1'b1;
                executeWord.srcASelect = 1'b1;
                if (executeStep == 2'd2) begin
                    executeWord.regWrite = 1'b1;
                    executeWord.regDestSelect = controlPkg::regDestRd;
                end
            end
            controlPkg::classAddi: begin
                executeWord.srcASelect = 1'b1;
                if (executeStep == 2'd1) begin
                    executeWord.aluOp = controlPkg::aluSub;
                    executeWord.aluOutWrite = 1'b1;
                    executeWord.srcBSelect = controlPkg::srcBImmediate;
                end else begin
                    // write-back step, rt is the destination
                    executeWord.aluOp = controlPkg::aluAdd;
                    executeWord.regWrite = 1'b1;
                end
            end
            controlPkg::classSlt: begin
                executeWord.aluOp = controlPkg::aluSlt;
                executeWord.srcASelect = 1'b1;
                executeWord.regWrite = 1'b1;
                executeWord.regDestSelect = controlPkg::regDestRd;
                executeWord.memToRegSelect = controlPkg::memToRegLessThan;
            end
            controlPkg::classShiftImmediate,
            controlPkg::classShiftVariable: begin
                executeWord.regDestSelect = controlPkg::regDestRd;
                executeWord.memToRegSelect = controlPkg::memToRegShifter;
                case (executeStep)
                    2'd1: begin
                        // immediate shifts take shamt and rt instead of rs and rt
                        executeWord.shiftCtrl = controlPkg::shiftLoad;
                        if (activeClass == controlPkg::classShiftImmediate) begin
                            executeWord.shiftAmountSelect = 1'b1;
                            executeWord.shiftSourceSelect = 1'b1;
                        end
                    end
                    2'd2: begin
                        executeWord.shiftCtrl = shiftDirection;
                    end
                    default: begin
                        executeWord.shiftCtrl = controlPkg::shiftLeft;
                        executeWord.regWrite = 1'b1;
                    end
                endcase
            end
            default: begin
                executeWord = controlPkg::idleWord;
            end
        endcase
    end

endmodule

//--- verilog/fetchDecodeSequencer.sv
`timescale 1ns/1ns

module fetchDecodeSequencer (
    input  logic                    clock,
    input  logic                    reset,
    input  controlPkg::opcodeT      opcode,
    input  controlPkg::functT       funct,
    input  logic                    done,
    output logic                    dispatch,
    output controlPkg::instrClassT  instrClass,
    output controlPkg::aluOpT       aluOp,
    output controlPkg::controlWordT fetchWord
);

    localparam logic [2:0] loadStep = 3'(controlPkg::fetchWaitCycles);
    localparam logic [2:0] operandStep = loadStep + 3'd1;
    localparam logic [2:0] decodeStep = loadStep + 3'd2;

    logic [2:0] stepCount;
    logic       waitingExecute;
    logic       atDecode;

    // decode lasts a single cycle, after that the counter just parks until done
    assign atDecode = (stepCount == decodeStep) && !waitingExecute;
    assign dispatch = atDecode && (instrClass != controlPkg::classNone);

    always_ff @(posedge clock) begin
        if (reset) begin
            stepCount <= '0;
            waitingExecute <= 1'b0;
        end else if (done) begin
            stepCount <= '0;
            waitingExecute <= 1'b0;
        end else if (atDecode) begin
            if (dispatch) begin
                waitingExecute <= 1'b1;
            end else begin
                stepCount <= '0;
            end
        end else if (!waitingExecute) begin
            stepCount <= stepCount + 3'd1;
        end
    end

    // shifts reuse the alu field as a direction tag: add is left, sub is
    // logical right and and is arithmetic right
    always_comb begin
        instrClass = controlPkg::classNone;
        aluOp = controlPkg::aluNone;
        if (opcode == controlPkg::opcodeAddi) begin
            instrClass = controlPkg::classAddi;
        end else if (opcode == controlPkg::opcodeRType) begin
            case (funct)
                controlPkg::functAdd: begin
                    instrClass = controlPkg::classAlu;
                    aluOp = controlPkg::aluAdd;
                end
                controlPkg::functSub: begin
                    instrClass = controlPkg::classAlu;
                    aluOp = controlPkg::aluSub;
                end
                controlPkg::functAnd: begin
                    instrClass = controlPkg::classAlu;
                    aluOp = controlPkg::aluAnd;
                end
                controlPkg::functSlt: begin
                    instrClass = controlPkg::classSlt;
                    aluOp = controlPkg::aluSlt;
                end
                controlPkg::functSll: begin
                    instrClass = controlPkg::classShiftImmediate;
                    aluOp = controlPkg::aluAdd;
                end
                controlPkg::functSrl: begin
                    instrClass = controlPkg::classShiftImmediate;
                    aluOp = controlPkg::aluSub;
                end
                controlPkg::functSra: begin
                    instrClass = controlPkg::classShiftImmediate;
                    aluOp = controlPkg::aluAnd;
                end
                controlPkg::functSllv: begin
                    instrClass = controlPkg::classShiftVariable;
                    aluOp = controlPkg::aluAdd;
                end
                controlPkg::functSrav: begin
                    instrClass = controlPkg::classShiftVariable;
                    aluOp = controlPkg::aluAnd;
                end
                default: begin
                    instrClass = controlPkg::classNone;
                end
            endcase
        end
    end

    always_comb begin
        fetchWord = controlPkg::idleWord;
        if (stepCount <= loadStep) begin
            // pc + 4 stays on the alu while memory answers
            fetchWord.aluOp = controlPkg::aluAdd;
            fetchWord.srcBSelect = controlPkg::srcBFour;
            fetchWord.pcWrite = (stepCount == loadStep);
            fetchWord.irWrite = (stepCount == loadStep);
        end else if (stepCount == operandStep) begin
            fetchWord.aWrite = 1'b1;
            fetchWord.bWrite = 1'b1;
        end
    end

endmodule
